// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing -j 0
LINT     = --lint-only --timing -Wall
TOP      = tb_cpu_frontend
FILELIST = vlog.f
OBJ_DIR  = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(SIM) $(LINT) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: bench/frontend_model.svh
`ifndef FRONTEND_MODEL_SVH
`define FRONTEND_MODEL_SVH

// Reference state, indexed like the DUT stages
pipe_pkg::stage_t m_stage [5];
pipe_pkg::side_t  m_side [4];			// Entry 0 unused
pipe_pkg::fetch_t m_skid [SKID_DEPTH];
logic [1:0]  m_mask;					// Masked fetch cycles left
logic [1:0]  m_replay;					// Skid words still to replay
logic        m_bank_next;				// Second skid write due
logic        m_stall_prev;
logic        m_int_en;
logic [15:0] m_target;					// Branch target seen on the last edge
logic [11:0] m_imm_hi;
logic [15:0] m_imm;
int          m_wr_idx;
int          m_rd_idx;
int          m_stall_cycles;
int          m_int_count;

function automatic logic has_op(pipe_pkg::stage_t s, logic [3:0] op);
	return s.instr.rf.opcode == op;
endfunction

// {stage 2 hit, stage 3 hit}, register 0 never matches
function automatic logic [1:0] load_hits();
	logic [3:0] src;
	src = m_stage[1].instr.rf.src;
	if (src == 4'd0)
		return 2'b00;
	return {has_op(m_stage[2], isa_pkg::OP_LOAD) && (m_side[2].dest == src),
		has_op(m_stage[3], isa_pkg::OP_LOAD) && (m_side[3].dest == src)};
endfunction

function automatic logic branch_in_pipe();
	logic found;
	found = 1'b0;
	for (int i = 0; i < 5; i++) begin
		if (has_op(m_stage[i], isa_pkg::OP_BRANCH))
			found = 1'b1;
	end
	return found;
endfunction

// Loads write a register but no flags, ALU words write both
function automatic pipe_pkg::side_t decode_side(isa_pkg::instr_t w);
	pipe_pkg::side_t s;
	s.dest = w.rf.dest;
	s.modifies_flags = 1'b1;
	case (w.rf.opcode)
		isa_pkg::OP_SYS, isa_pkg::OP_IMM, isa_pkg::OP_BRANCH: s = '0;
		isa_pkg::OP_LOAD: s.modifies_flags = 1'b0;
		default: ;
	endcase
	return s;
endfunction

// Word that enters stage 0 on a normal advance
function automatic pipe_pkg::stage_t next_fetch_slot(pipe_pkg::fetch_t f, logic fetch_ok,
		logic take_int, logic [3:0] irq_num);
	pipe_pkg::stage_t s;
	if (take_int) begin
		s.instr = isa_pkg::INT_BASE | {12'h000, irq_num};
		s.pc = f.addr - (has_op(m_stage[0], isa_pkg::OP_IMM) ? 16'd2 : 16'd1);
	end else if (fetch_ok) begin
		s.instr = f.instr;
		s.pc = f.addr;
	end else if (m_replay != 2'd0) begin
		s.instr = m_skid[m_rd_idx].instr;
		s.pc = m_skid[m_rd_idx].addr;
	end else begin
		s.instr = isa_pkg::NOP_WORD;
		s.pc = m_target;
	end
	return s;
endfunction

task automatic model_reset();
	for (int i = 0; i < 5; i++) begin
		m_stage[i] = '0;
	end
	for (int i = 0; i < 4; i++) begin
		m_side[i] = '0;
	end
	m_mask = 2'd2;
	m_replay = 2'd0;
	m_bank_next = 1'b0;
	m_stall_prev = 1'b0;
	m_int_en = 1'b0;
	m_target = '0;
	m_imm_hi = '0;
	m_imm = '0;
	m_wr_idx = 0;
	m_rd_idx = 0;
endtask

// One rising edge with the inputs the DUT samples on it
task automatic model_step(input pipe_pkg::fetch_t f, input logic exec, input logic load,
		input logic [15:0] target, input logic set, input logic clr, input logic intr,
		input logic [3:0] irq_num, input logic rst_n);
	pipe_pkg::stage_t nxt [5];
	pipe_pkg::side_t nside [4];
	logic [1:0] hits;
	logic hz;
	logic first;
	logic last;
	logic fetch_ok;
	logic take_int;
	logic taken;
	logic rd;
	logic wr;
	logic [11:0] hi_next;

	if (!rst_n) begin
		model_reset();
		return;
	end

	hits = load_hits();
	hz = hits != 2'b00;
	first = hz && !m_stall_prev;
	last = hz && !hits[1];				// Only stage 3 still matches
	fetch_ok = (m_mask == 2'd0) && (m_replay == 2'd0) && f.is_instr;
	take_int = fetch_ok && m_int_en && intr && !branch_in_pipe();
	taken = exec && take_int && !hz;
	rd = exec && !hz && (m_replay != 2'd0);
	wr = (first || m_bank_next) && !load;

	nxt = m_stage;
	nside = m_side;
	nxt[4].instr = isa_pkg::NOP_WORD;
	if (exec && hz) begin
		nxt[4] = m_stage[3];
		nxt[3] = m_stage[2];
		nxt[2].instr = isa_pkg::NOP_WORD;	// Bubble
		nxt[2].pc = m_stage[1].pc;
		nside[3] = m_side[2];
		nside[2] = '0;
	end else if (exec) begin
		for (int i = 4; i > 0; i--) begin
			nxt[i] = m_stage[i-1];
		end
		nside[3] = m_side[2];
		nside[2] = m_side[1];
		nside[1] = decode_side(m_stage[0].instr);
		nxt[0] = next_fetch_slot(f, fetch_ok, take_int, irq_num);
	end
	if (load) begin
		for (int i = 0; i < 3; i++) begin
			nxt[i].instr = isa_pkg::NOP_WORD;
		end
		for (int i = 1; i < 4; i++) begin
			nside[i] = '0;
		end
	end

	// Upper immediate survives NOPs and stalls
	if (!load && has_op(m_stage[1], isa_pkg::OP_IMM))
		hi_next = m_stage[1].instr.pf.imm_hi;
	else if (!exec || (!load && (hz || (m_stage[1].instr == isa_pkg::NOP_WORD))))
		hi_next = m_imm_hi;
	else
		hi_next = '0;
	if (exec)
		m_imm = {m_imm_hi, m_stage[1].instr.rf.imm_lo};
	m_imm_hi = hi_next;

	if (wr) begin
		m_skid[m_wr_idx] = f;
		if (!f.is_instr) begin
			m_skid[m_wr_idx].instr = isa_pkg::NOP_WORD;
			m_skid[m_wr_idx].addr = '0;
		end
	end
	if (load) begin
		m_wr_idx = 0;
		m_rd_idx = 0;
	end else begin
		if (wr)
			m_wr_idx = (m_wr_idx + 1) % SKID_DEPTH;
		if (rd)
			m_rd_idx = (m_rd_idx + 1) % SKID_DEPTH;
	end

	if (load)
		m_mask = 2'd2;
	else if (exec && (m_mask != 2'd0))
		m_mask = m_mask - 2'd1;
	if (load)
		m_replay = 2'd0;
	else if (last)
		m_replay = 2'd2;
	else if (rd)
		m_replay = m_replay - 2'd1;
	m_bank_next = first && !load;
	m_stall_prev = hz;
	m_target = target;
	if (clr || taken)
		m_int_en = 1'b0;
	else if (set)
		m_int_en = 1'b1;

	m_stage = nxt;
	m_side = nside;
	if (hz)
		m_stall_cycles++;
	if (taken)
		m_int_count++;
endtask

`endif

// File: bench/tb_cpu_frontend.sv
`timescale 1ns/10ps
`default_nettype none

module tb_cpu_frontend;

	localparam int SKID_DEPTH     = 8;
	localparam int RESET_CYCLES   = 2;
	localparam int NUM_CYCLES     = 3000;
	localparam int TIMEOUT_CYCLES = NUM_CYCLES + NUM_CYCLES / 3;	// Margin over the stimulus

	logic CLK;
	logic RSTb;
	pipe_pkg::fetch_t fetch;
	logic is_executing;
	logic load_pc;
	logic [pipe_pkg::ADDR_BITS-1:0] pc_in;
	logic int_set;
	logic int_clear;
	logic interrupt;
	logic [3:0] irq;
	pipe_pkg::stage_t stage0;
	pipe_pkg::stage_t stage1;
	pipe_pkg::stage_t stage2;
	pipe_pkg::stage_t stage3;
	pipe_pkg::stage_t stage4;
	pipe_pkg::side_t side1;
	pipe_pkg::side_t side2;
	pipe_pkg::side_t side3;
	logic [isa_pkg::WORD_BITS-1:0] imm_reg;
	logic stall;
	logic wake;

	logic [15:0] fetch_pc;			// Memory side fetch counter
	int cycle_count = 0;

	`include "frontend_model.svh"

	cpu_frontend #(
		.SKID_DEPTH (SKID_DEPTH)
	) UUT (
		.CLK (CLK), .RSTb (RSTb), .fetch (fetch), .is_executing (is_executing),
		.load_pc (load_pc), .pc_in (pc_in), .int_set (int_set), .int_clear (int_clear),
		.interrupt (interrupt), .irq (irq),
		.stage0 (stage0), .stage1 (stage1), .stage2 (stage2), .stage3 (stage3),
		.stage4 (stage4), .side1 (side1), .side2 (side2), .side3 (side3),
		.imm_reg (imm_reg), .stall (stall), .wake (wake)
	);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: run still going after %0d clock cycles", cycle_count);
			$display("Testbench failed");
			$fatal(1);
		end
	end

	task automatic check_stage(input string name, input pipe_pkg::stage_t got,
			input pipe_pkg::stage_t want);
		if (got !== want) begin
			$display("ERROR at %0t: %s is %h, expected %h", $time, name, got, want);
			$display("Testbench failed");
			$fatal(1);
		end
	endtask

	task automatic check_side(input string name, input pipe_pkg::side_t got,
			input pipe_pkg::side_t want);
		if (got !== want) begin
			$display("ERROR at %0t: %s is %h, expected %h", $time, name, got, want);
			$display("Testbench failed");
			$fatal(1);
		end
	endtask

	task automatic check_word(input string name, input logic [isa_pkg::WORD_BITS-1:0] got,
			input logic [isa_pkg::WORD_BITS-1:0] want);
		if (got !== want) begin
			$display("ERROR at %0t: %s is %h, expected %h", $time, name, got, want);
			$display("Testbench failed");
			$fatal(1);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic want);
		if (got !== want) begin
			$display("ERROR at %0t: %s is %b, expected %b", $time, name, got, want);
			$display("Testbench failed");
			$fatal(1);
		end
	endtask

	// Weighted mix of loads, prefixes, branches, NOPs and ALU words
	function automatic isa_pkg::instr_t random_instr();
		isa_pkg::instr_t w;
		int unsigned pick;
		pick = $urandom_range(99);
		w.rf.opcode = 4'($urandom_range(15, 5));
		w.rf.dest = 4'($urandom_range(3));	// Few registers keep hazards frequent
		w.rf.src = 4'($urandom_range(3));
		w.rf.imm_lo = 4'($urandom_range(15));
		if (pick < 25) begin
			w.rf.opcode = isa_pkg::OP_LOAD;
		end else if (pick < 40) begin
			w.pf.opcode = isa_pkg::OP_IMM;
			w.pf.imm_hi = 12'($urandom);
		end else if (pick < 45) begin
			w.rf.opcode = isa_pkg::OP_BRANCH;
		end else if (pick < 50) begin
			w = isa_pkg::NOP_WORD;
		end
		return w;
	endfunction

	task automatic drive_inputs();
		pipe_pkg::fetch_t f;
		logic jump;
		logic [15:0] target;
		jump = $urandom_range(99) < 3;
		target = 16'($urandom);
		f.instr = random_instr();
		f.is_instr = $urandom_range(99) < 85;
		f.addr = fetch_pc + 16'd1;
		if (jump)
			fetch_pc = target;
		else if (f.is_instr)
			fetch_pc = fetch_pc + 16'd1;
		fetch <= f;
		load_pc <= jump;
		pc_in <= target;
		is_executing <= $urandom_range(99) < 92;	// Short pauses
		int_set <= $urandom_range(99) < 6;
		int_clear <= $urandom_range(99) < 3;
		interrupt <= $urandom_range(99) < 25;
		irq <= 4'($urandom_range(15));
	endtask

	task automatic compare_outputs();
		check_stage("stage0", stage0, m_stage[0]);
		check_stage("stage1", stage1, m_stage[1]);
		check_stage("stage2", stage2, m_stage[2]);
		check_stage("stage3", stage3, m_stage[3]);
		check_stage("stage4", stage4, m_stage[4]);
		check_side("side1", side1, m_side[1]);
		check_side("side2", side2, m_side[2]);
		check_side("side3", side3, m_side[3]);
		check_word("imm_reg", imm_reg, m_imm);
		check_bit("stall", stall, load_hits() != 2'b00);
		check_bit("wake", wake, interrupt);
	endtask

	initial begin
		void'($urandom(90));
		RSTb = 1'b0;
		fetch = '0;
		is_executing = 1'b0;
		load_pc = 1'b0;
		pc_in = '0;
		int_set = 1'b0;
		int_clear = 1'b0;
		interrupt = 1'b0;
		irq = '0;
		fetch_pc = '0;
		m_stall_cycles = 0;
		m_int_count = 0;
		model_reset();
		for (int cyc = 0; cyc < RESET_CYCLES + NUM_CYCLES; cyc++) begin
			@(posedge CLK);
			model_step(fetch, is_executing, load_pc, pc_in, int_set, int_clear, interrupt,
				irq, RSTb);
			if (cyc == RESET_CYCLES - 1)
				RSTb <= 1'b1;
			if (cyc >= RESET_CYCLES - 1)
				drive_inputs();
			@(negedge CLK);				// Registered outputs settled
			compare_outputs();
		end
		$display("Ran %0d cycles with %0d stall cycles and %0d interrupts injected",
			NUM_CYCLES, m_stall_cycles, m_int_count);
		if ((m_stall_cycles == 0) || (m_int_count == 0)) begin
			$display("Random stream never reached a load-use stall or an interrupt injection");
			$display("Testbench failed");
			$fatal(1);
		end else begin
			$display("Testbench passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: rtl/cpu_frontend.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_frontend #(
	parameter int SKID_DEPTH = 8
) (
	input  wire logic                           CLK,
	input  wire logic                           RSTb,
	input  wire pipe_pkg::fetch_t               fetch,
	input  wire logic                           is_executing,
	input  wire logic                           load_pc,
	input  wire logic [pipe_pkg::ADDR_BITS-1:0] pc_in,
	input  wire logic                           int_set,
	input  wire logic                           int_clear,
	input  wire logic                           interrupt,
	input  wire logic [3:0]                     irq,
	output pipe_pkg::stage_t                    stage0,
	output pipe_pkg::stage_t                    stage1,
	output pipe_pkg::stage_t                    stage2,
	output pipe_pkg::stage_t                    stage3,
	output pipe_pkg::stage_t                    stage4,
	output pipe_pkg::side_t                     side1,
	output pipe_pkg::side_t                     side2,
	output pipe_pkg::side_t                     side3,
	output logic [isa_pkg::WORD_BITS-1:0]       imm_reg,
	output logic                                stall,
	output logic                                wake
);

	logic stall_start;
	logic stall_end;
	logic op2_load;
	logic op3_load;
	logic skid_wr;
	logic skid_rd;
	logic int_enabled;
	logic int_taken;
	pipe_pkg::fetch_t skid_word;

	instr_pipeline u_pipe (
		.CLK          (CLK),
		.RSTb         (RSTb),
		.fetch        (fetch),
		.is_executing (is_executing),
		.load_pc      (load_pc),
		.pc_in        (pc_in),
		.stall        (stall),
		.stall_start  (stall_start),
		.stall_end    (stall_end),
		.skid_word    (skid_word),
		.int_enabled  (int_enabled),
		.interrupt    (interrupt),
		.irq          (irq),
		.stage0       (stage0),
		.stage1       (stage1),
		.stage2       (stage2),
		.stage3       (stage3),
		.stage4       (stage4),
		.side1        (side1),
		.side2        (side2),
		.side3        (side3),
		.op2_load     (op2_load),
		.op3_load     (op3_load),
		.imm_reg      (imm_reg),
		.skid_wr      (skid_wr),
		.skid_rd      (skid_rd),
		.int_taken    (int_taken)
	);

	hazard_unit u_hazard (
		.CLK         (CLK),
		.RSTb        (RSTb),
		.stage1      (stage1),
		.side2       (side2),
		.side3       (side3),
		.op2_load    (op2_load),
		.op3_load    (op3_load),
		.stall       (stall),
		.stall_start (stall_start),
		.stall_end   (stall_end)
	);

	// Banked fetch words, emptied on a PC load
	skid_buffer #(
		.SKID_DEPTH (SKID_DEPTH)
	) u_skid (
		.CLK     (CLK),
		.RSTb    (RSTb),
		.flush   (load_pc),
		.wr      (skid_wr),
		.wr_word (fetch),
		.rd      (skid_rd),
		.rd_word (skid_word)
	);

	irq_regs u_irq (
		.CLK         (CLK),
		.RSTb        (RSTb),
		.int_set     (int_set),
		.int_clear   (int_clear),
		.int_taken   (int_taken),
		.interrupt   (interrupt),
		.int_enabled (int_enabled),
		.wake        (wake)
	);

endmodule

`default_nettype wire

// File: rtl/hazard_unit.sv
`timescale 1ns/10ps
`default_nettype none

module hazard_unit (
	input  wire logic             CLK,
	input  wire logic             RSTb,
	input  wire pipe_pkg::stage_t stage1,
	input  wire pipe_pkg::side_t  side2,
	input  wire pipe_pkg::side_t  side3,
	input  wire logic             op2_load,
	input  wire logic             op3_load,
	output logic                  stall,
	output logic                  stall_start,
	output logic                  stall_end
);

	logic [isa_pkg::REG_BITS-1:0] src1;
	logic hit2;
	logic hit3;
	logic stall_q;

	assign src1 = stage1.instr.rf.src;

	// Load results are not ready until write-back
	assign hit2 = op2_load && (side2.dest == src1);
	assign hit3 = op3_load && (side3.dest == src1);

	assign stall = (src1 != '0) && (hit2 || hit3);	// R0 never creates a dependency

	assign stall_start = stall && !stall_q;

	// A stage 2 hit turns into a stage 3 hit on the next edge,
	// so the stall only finishes once stage 3 alone still matches
	assign stall_end = stall && !hit2;

	always_ff @(posedge CLK) begin
		if (!RSTb)
			stall_q <= 1'b0;
		else
			stall_q <= stall;
	end

endmodule

`default_nettype wire

// File: rtl/instr_pipeline.sv
`timescale 1ns/10ps
`default_nettype none

module instr_pipeline (
	input  wire logic                           CLK,
	input  wire logic                           RSTb,
	input  wire pipe_pkg::fetch_t               fetch,
	input  wire logic                           is_executing,
	input  wire logic                           load_pc,
	input  wire logic [pipe_pkg::ADDR_BITS-1:0] pc_in,
	input  wire logic                           stall,
	input  wire logic                           stall_start,
	input  wire logic                           stall_end,
	input  wire pipe_pkg::fetch_t               skid_word,
	input  wire logic                           int_enabled,
	input  wire logic                           interrupt,
	input  wire logic [3:0]                     irq,
	output pipe_pkg::stage_t                    stage0,
	output pipe_pkg::stage_t                    stage1,
	output pipe_pkg::stage_t                    stage2,
	output pipe_pkg::stage_t                    stage3,
	output pipe_pkg::stage_t                    stage4,
	output pipe_pkg::side_t                     side1,
	output pipe_pkg::side_t                     side2,
	output pipe_pkg::side_t                     side3,
	output logic                                op2_load,
	output logic                                op3_load,
	output logic [isa_pkg::WORD_BITS-1:0]       imm_reg,
	output logic                                skid_wr,
	output logic                                skid_rd,
	output logic                                int_taken
);

	pipe_pkg::stage_t st [5];
	pipe_pkg::stage_t st_n [5];
	pipe_pkg::side_t sd [1:3];
	pipe_pkg::side_t sd_n [1:3];
	pipe_pkg::side_t side0;		// Decode of the word now in stage 0

	logic [1:0] mask_cnt;		// Fetch mask after reset or PC load
	logic [1:0] stall_mask_cnt;	// Skid replay cycles left
	logic skid_win;				// Second skid write cycle
	logic [pipe_pkg::ADDR_BITS-1:0] branch_target;
	logic [isa_pkg::WORD_BITS-5:0] imm_hi;
	logic [isa_pkg::WORD_BITS-5:0] imm_hi_n;

	logic take_fetch;
	logic branch_in_flight;
	logic inject;
	isa_pkg::instr_t int_word;

	always_comb begin
		side0.dest = st[0].instr.rf.dest;
		side0.modifies_flags = 1'b1;	// ALU class by default
		case (st[0].instr.rf.opcode)
			isa_pkg::OP_SYS, isa_pkg::OP_IMM, isa_pkg::OP_BRANCH: begin
				side0.dest = '0;
				side0.modifies_flags = 1'b0;
			end
			isa_pkg::OP_LOAD: side0.modifies_flags = 1'b0;
			default: ;
		endcase
	end

	// A branch anywhere may still redirect the PC
	always_comb begin
		branch_in_flight = 1'b0;
		for (int i = 0; i < 5; i++) begin
			if (st[i].instr.rf.opcode == isa_pkg::OP_BRANCH)
				branch_in_flight = 1'b1;
		end
	end

	always_comb begin
		int_word = isa_pkg::INT_BASE;
		int_word.rf.imm_lo = irq;
	end

	assign take_fetch = (mask_cnt == '0) && (stall_mask_cnt == '0) && fetch.is_instr;
	assign inject     = take_fetch && int_enabled && interrupt && !branch_in_flight;
	assign int_taken  = is_executing && inject && !stall;
	assign skid_rd    = is_executing && !stall && (stall_mask_cnt != '0);
	assign skid_wr    = (stall_start || skid_win) && !load_pc;

	assign op2_load = st[2].instr.rf.opcode == isa_pkg::OP_LOAD;
	assign op3_load = st[3].instr.rf.opcode == isa_pkg::OP_LOAD;

	always_comb begin
		st_n = st;
		sd_n = sd;
		st_n[4].instr = isa_pkg::NOP_WORD;	// Write-back drains while paused

		if (is_executing) begin
			if (take_fetch) begin
				st_n[0].instr = fetch.instr;
				st_n[0].pc = fetch.addr;
				if (inject) begin
					st_n[0].instr = int_word;
					// Return to the prefix, not to its second half
					if (st[0].instr.rf.opcode == isa_pkg::OP_IMM)
						st_n[0].pc = fetch.addr - 2'd2;
					else
						st_n[0].pc = fetch.addr - 2'd1;
				end
			end else if (stall_mask_cnt != '0) begin
				st_n[0].instr = skid_word.instr;	// Replay words banked during the stall
				st_n[0].pc = skid_word.addr;
			end else begin
				st_n[0].instr = isa_pkg::NOP_WORD;
				st_n[0].pc = branch_target;		// Resume point if an INT lands here
			end

			for (int i = 1; i < 5; i++) begin
				st_n[i] = st[i-1];
			end
			sd_n[1] = side0;
			sd_n[2] = sd[1];
			sd_n[3] = sd[2];

			// Load-use: hold fetch and decode, bubble into execute
			if (stall) begin
				st_n[0] = st[0];
				st_n[1] = st[1];
				st_n[2].instr = isa_pkg::NOP_WORD;
				sd_n[1] = sd[1];
				sd_n[2] = '0;
			end
		end

		// Words behind a taken branch never execute
		if (load_pc) begin
			for (int i = 0; i < 3; i++) begin
				st_n[i].instr = isa_pkg::NOP_WORD;
			end
			for (int i = 1; i < 4; i++) begin
				sd_n[i] = '0;
			end
		end
	end

	always_comb begin
		imm_hi_n = '0;
		if ((st[1].instr == isa_pkg::NOP_WORD) && !load_pc)
			imm_hi_n = imm_hi;
		if (!is_executing || (stall && !load_pc))
			imm_hi_n = imm_hi;
		if ((st[1].instr.pf.opcode == isa_pkg::OP_IMM) && !load_pc)
			imm_hi_n = st[1].instr.pf.imm_hi;
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			for (int i = 0; i < 5; i++) begin
				st[i].instr <= isa_pkg::NOP_WORD;
				st[i].pc <= '0;
			end
			for (int i = 1; i < 4; i++) begin
				sd[i] <= '0;
			end
			mask_cnt <= 2'd2;
			stall_mask_cnt <= '0;
			skid_win <= 1'b0;
			branch_target <= '0;
			imm_hi <= '0;
			imm_reg <= '0;
		end else begin
			st <= st_n;
			sd <= sd_n;

			if (load_pc)
				mask_cnt <= 2'd2;
			else if (is_executing && (mask_cnt != '0))
				mask_cnt <= mask_cnt - 1'b1;

			if (load_pc)
				stall_mask_cnt <= '0;	// Banked words belong to the old path
			else if (stall_end)
				stall_mask_cnt <= 2'd2;
			else if (skid_rd)
				stall_mask_cnt <= stall_mask_cnt - 1'b1;

			skid_win <= stall_start && !load_pc;
			branch_target <= pc_in;
			imm_hi <= imm_hi_n;
			if (is_executing)
				imm_reg <= {imm_hi, st[1].instr.rf.imm_lo};
		end
	end

	assign stage0 = st[0];
	assign stage1 = st[1];
	assign stage2 = st[2];
	assign stage3 = st[3];
	assign stage4 = st[4];
	assign side1 = sd[1];
	assign side2 = sd[2];
	assign side3 = sd[3];

endmodule

`default_nettype wire

// File: rtl/irq_regs.sv
`timescale 1ns/10ps
`default_nettype none

module irq_regs (
	input  wire logic CLK,
	input  wire logic RSTb,
	input  wire logic int_set,
	input  wire logic int_clear,
	input  wire logic int_taken,	// INT injected into the pipeline
	input  wire logic interrupt,
	output logic      int_enabled,
	output logic      wake
);

	always_ff @(posedge CLK) begin
		if (!RSTb)
			int_enabled <= 1'b0;
		else if (int_clear || int_taken)	// Clear wins over set
			int_enabled <= 1'b0;
		else if (int_set)
			int_enabled <= 1'b1;
	end

	// Any pending interrupt wakes a sleeping core, enabled or not
	assign wake = interrupt;

endmodule

`default_nettype wire

// File: rtl/isa_pkg.sv
`default_nettype none

package isa_pkg;

	localparam int WORD_BITS = 16;	// Instruction width
	localparam int REG_BITS  = 4;	// Register index width

	// Major opcodes, top nibble of every word
	localparam logic [3:0] OP_SYS    = 4'd0;	// NOP and INT
	localparam logic [3:0] OP_IMM    = 4'd1;	// Immediate prefix
	localparam logic [3:0] OP_LOAD   = 4'd3;
	localparam logic [3:0] OP_BRANCH = 4'd4;

	localparam logic [WORD_BITS-1:0] NOP_WORD = '0;

	// INT instruction, the irq number fills the low nibble
	localparam logic [WORD_BITS-1:0] INT_BASE = 16'h0050 << 4;

	// Register form: op | rd | rs | imm_lo
	typedef struct packed {
		logic [3:0]          opcode;
		logic [REG_BITS-1:0] dest;
		logic [REG_BITS-1:0] src;
		logic [3:0]          imm_lo;
	} reg_form_t;

	// Prefix form: op | upper 12 bits of the next immediate
	typedef struct packed {
		logic [3:0]           opcode;
		logic [WORD_BITS-5:0] imm_hi;
	} imm_form_t;

	typedef union packed {
		reg_form_t rf;
		imm_form_t pf;
	} instr_t;

endpackage

`default_nettype wire

// File: rtl/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

	localparam int ADDR_BITS = 16;	// Fetch address width, fixed by the ISA

	// Word coming back from memory
	typedef struct packed {
		isa_pkg::instr_t      instr;
		logic [ADDR_BITS-1:0] addr;		// PC + 1 of the fetch
		logic                 is_instr;	// Slot carries a real instruction
	} fetch_t;

	// Hazard info that rides along with a stage
	typedef struct packed {
		logic [isa_pkg::REG_BITS-1:0] dest;
		logic                         modifies_flags;
	} side_t;

	typedef struct packed {
		isa_pkg::instr_t      instr;
		logic [ADDR_BITS-1:0] pc;
	} stage_t;

endpackage

`default_nettype wire

// File: rtl/skid_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module skid_buffer #(
	parameter int SKID_DEPTH = 8
) (
	input  wire logic             CLK,
	input  wire logic             RSTb,
	input  wire logic             flush,
	input  wire logic             wr,
	input  wire pipe_pkg::fetch_t wr_word,
	input  wire logic             rd,
	output pipe_pkg::fetch_t      rd_word
);

	localparam int PTR_BITS = $clog2(SKID_DEPTH);

	pipe_pkg::fetch_t mem [SKID_DEPTH];
	pipe_pkg::fetch_t store_word;
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;

	// Empty fetch slots are kept as a plain NOP
	always_comb begin
		store_word = wr_word;
		if (!wr_word.is_instr) begin
			store_word.instr = isa_pkg::NOP_WORD;
			store_word.addr  = '0;
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr)
				wr_ptr <= wr_ptr + 1'b1;	// Wraps, depth is a power of two
			if (rd)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (wr)
			mem[wr_ptr] <= store_word;
	end

	assign rd_word = mem[rd_ptr];

endmodule

`default_nettype wire

// File: vlog.f
+incdir+bench
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/hazard_unit.sv
rtl/irq_regs.sv
rtl/skid_buffer.sv
rtl/instr_pipeline.sv
rtl/cpu_frontend.sv
bench/tb_cpu_frontend.sv
